//--- eeprom_rw.f
hdl/eeprom_pkg.sv
hdl/i2c_bit_timer.sv
hdl/i2c_bus_cond.sv
hdl/i2c_byte_shifter.sv
hdl/eeprom_ctrl.sv
hdl/eeprom_rw_top.sv
tb/eeprom_model.sv
tb/eeprom_rw_sva.sv
tb/eeprom_rw_tb.sv

//--- Bender.yml
package:
  name: eeprom_rw

sources:
  # design sources in compile order
  - target: any(rtl, simulation)
    files:
      - hdl/eeprom_pkg.sv
      - hdl/i2c_bit_timer.sv
      - hdl/i2c_bus_cond.sv
      - hdl/i2c_byte_shifter.sv
      - hdl/eeprom_ctrl.sv
      - hdl/eeprom_rw_top.sv

  # testbench, bus model and bound assertions
  - target: test
    files:
      - tb/eeprom_model.sv
      - tb/eeprom_rw_sva.sv
      - tb/eeprom_rw_tb.sv

//--- tb/eeprom_rw_tb.sv
module eeprom_rw_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int BIT_CYCLES     = 4 * eeprom_pkg::QUARTER_CYCLES;
    localparam int WRITE_CYCLES   = 29 * BIT_CYCLES;
    localparam int READ_CYCLES    = 39 * BIT_CYCLES;
    localparam int TIMEOUT_CYCLES = 64 * READ_CYCLES;  // 42 transactions need about 27k cycles

    logic                    CLK;
    logic                    RESET;
    logic                    req_valid;
    eeprom_pkg::eeprom_req_t req;
    logic                    busy;
    logic                    rsp_valid;
    eeprom_pkg::eeprom_rsp_t rsp;
    logic                    scl;
    logic                    dut_sda_low;
    logic                    model_sda_low;
    logic [3:0]              model_code;
    wire                     sda_bus;
    logic [7:0]              ref_mem [eeprom_pkg::MEM_BYTES];
    int                      errors    = 0;
    int                      rsp_count = 0;
    int                      cycle_cnt;

    assign sda_bus = !(dut_sda_low || model_sda_low);  // pull-up, either side pulls low

    eeprom_rw_top dut (
        .CLK       (CLK),
        .RESET     (RESET),
        .req_valid (req_valid),
        .req       (req),
        .busy      (busy),
        .rsp_valid (rsp_valid),
        .rsp       (rsp),
        .scl       (scl),
        .sda_low   (dut_sda_low),
        .sda_in    (sda_bus)
    );

    eeprom_model u_model (
        .scl         (scl),
        .sda         (sda_bus),
        .device_code (model_code),
        .sda_low     (model_sda_low)
    );

    bind eeprom_rw_top eeprom_rw_sva sva (
        .CLK         (CLK),
        .RESET       (RESET),
        .busy        (busy),
        .rsp_valid   (rsp_valid),
        .scl         (scl),
        .sda_in      (sda_in),
        .cond_active (u_cond.active)
    );

    initial begin
        CLK = 1'b0;
        forever #10 CLK = ~CLK;
    end

    always @(negedge CLK) begin
        if (rsp_valid === 1'b1) begin
            rsp_count++;
        end
    end

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            $display("error %s: expected %0h, actual %0h", name, expected, actual);
            errors++;
        end
    endtask

    // one request strobe, driven just after the clock edge
    task automatic issue(input logic wr, input logic [10:0] a, input logic [7:0] d);
        @(posedge CLK);
        #2;
        req_valid     = 1'b1;
        req.write     = wr;
        req.addr.flat = a;
        req.wdata     = d;
        @(posedge CLK);
        #2;
        req_valid = 1'b0;
    endtask

    task automatic wait_response(output eeprom_pkg::eeprom_rsp_t r);
        do @(negedge CLK); while (rsp_valid !== 1'b1);
        r = rsp;
    endtask

    task automatic transact(input logic wr, input logic [10:0] a, input logic [7:0] d,
                            output eeprom_pkg::eeprom_rsp_t r);
        while (busy !== 1'b0) @(negedge CLK);
        issue(wr, a, d);
        wait_response(r);
        if (wr) begin
            ref_mem[a] = d;
        end
    endtask

    task automatic write_byte(input string name, input logic [10:0] a, input logic [7:0] d);
        eeprom_pkg::eeprom_rsp_t r;
        transact(1'b1, a, d, r);
        check({name, " write ack_error"}, 0, r.ack_error);
    endtask

    task automatic read_compare(input string name, input logic [10:0] a);
        eeprom_pkg::eeprom_rsp_t r;
        transact(1'b0, a, 8'h00, r);
        check({name, " read ack_error"}, 0, r.ack_error);
        check({name, " rdata"}, ref_mem[a], r.rdata);
    endtask

    task automatic reset_state();
        @(negedge CLK);
        check("reset_state busy", 0, busy);
        check("reset_state rsp_valid", 0, rsp_valid);
        check("reset_state scl", 1, scl);
        check("reset_state sda_low", 0, dut_sda_low);
    endtask

    task automatic write_then_read();
        logic [10:0] a;
        a = 11'($urandom_range(eeprom_pkg::MEM_BYTES - 1));
        write_byte("write_then_read", a, 8'($urandom));
        read_compare("write_then_read", a);
    endtask

    // same word, every block, so only the control byte tells them apart
    task automatic block_bits();
        logic [7:0] w;
        w = 8'($urandom);
        for (int b = 0; b < 8; b++) begin
            write_byte("block_bits", {3'(b), w}, {5'($urandom), 3'(b)});
        end
        for (int b = 0; b < 8; b++) begin
            read_compare("block_bits", {3'(b), w});
        end
    endtask

    task automatic random_traffic();
        logic [10:0] base;
        logic [10:0] a;
        base = 11'($urandom_range(eeprom_pkg::MEM_BYTES - 32));  // small window, reads hit writes
        for (int i = 0; i < 20; i++) begin
            a = base + 11'($urandom_range(31));
            if ($urandom_range(1) == 1) begin
                write_byte("random_traffic", a, 8'($urandom));
            end else begin
                read_compare("random_traffic", a);
            end
        end
    endtask

    task automatic missing_ack();
        eeprom_pkg::eeprom_rsp_t r;
        model_code = eeprom_pkg::DEVICE_CODE ^ 4'b0001;
        transact(1'b0, 11'($urandom_range(eeprom_pkg::MEM_BYTES - 1)), 8'h00, r);
        check("missing_ack ack_error", 1, r.ack_error);
        check("missing_ack scl", 1, scl);
        check("missing_ack sda_low", 0, dut_sda_low);
        check("missing_ack sda", 1, sda_bus);
        model_code = eeprom_pkg::DEVICE_CODE;
    endtask

    task automatic ignored_request();
        eeprom_pkg::eeprom_rsp_t r;
        logic [10:0]             a;
        logic [7:0]              d;
        int                      count_before;
        a = 11'($urandom_range(eeprom_pkg::MEM_BYTES - 1));
        d = 8'($urandom);
        while (busy !== 1'b0) @(negedge CLK);
        count_before = rsp_count;
        issue(1'b1, a, d);
        repeat (BIT_CYCLES) @(negedge CLK);
        check("ignored_request busy", 1, busy);
        issue(1'b1, a ^ 11'h155, ~d);  // arrives mid-transaction
        wait_response(r);
        check("ignored_request ack_error", 0, r.ack_error);
        ref_mem[a] = d;
        repeat (WRITE_CYCLES) @(negedge CLK);  // room for a second completion
        check("ignored_request completions", count_before + 1, rsp_count);
        read_compare("ignored_request second address", a ^ 11'h155);
        read_compare("ignored_request first address", a);
    endtask

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge CLK);
            cycle_cnt++;
        end
        $display("timeout: tests did not finish within %0d clock cycles", TIMEOUT_CYCLES);
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        void'($urandom(32'h152cba4b));
        RESET      = 1'b1;
        req_valid  = 1'b0;
        req        = '0;
        model_code = eeprom_pkg::DEVICE_CODE;
        for (int i = 0; i < eeprom_pkg::MEM_BYTES; i++) begin
            ref_mem[i] = 8'hff;
        end
        repeat (10) @(posedge CLK);
        #2;
        RESET = 1'b0;
        reset_state();
        write_then_read();
        block_bits();
        random_traffic();
        missing_ack();
        ignored_request();
        $display("check errors: %0d, assertion failures: %0d", errors, dut.sva.fail_count);
        if (errors == 0 && dut.sva.fail_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

//--- tb/eeprom_rw_sva.sv
module eeprom_rw_sva (
    input logic CLK,
    input logic RESET,
    input logic busy,
    input logic rsp_valid,
    input logic scl,
    input logic sda_in,
    input logic cond_active
);

    timeunit 1ns;
    timeprecision 1ps;

    int unsigned fail_count = 0;

    // with scl high only a start or stop may move sda
    sda_steady_while_scl_high: assert property (
        @(posedge CLK) disable iff (RESET)
        (scl && $past(scl) && (sda_in != $past(sda_in))) |-> cond_active
    ) else begin
        fail_count++;
        $error("sda changed while scl was high outside a start or stop condition");
    end

    busy_falls_after_response: assert property (
        @(posedge CLK) disable iff (RESET)
        $fell(busy) |-> $past(rsp_valid)
    ) else begin
        fail_count++;
        $error("busy dropped without a response in the previous cycle");
    end

    response_single_cycle: assert property (
        @(posedge CLK) disable iff (RESET)
        rsp_valid |=> !rsp_valid
    ) else begin
        fail_count++;
        $error("rsp_valid stayed high for more than one cycle");
    end

endmodule

//--- tb/eeprom_model.sv
module eeprom_model (
    input  logic       scl,
    input  logic       sda,
    input  logic [3:0] device_code,
    output logic       sda_low
);

    timeunit 1ns;
    timeprecision 1ps;

    typedef enum logic [2:0] {
        F_CTRL,
        F_WORD,
        F_DATA_W,
        F_DATA_R,
        F_IGNORE
    } frame_e;

    logic [7:0]                       mem [eeprom_pkg::MEM_BYTES];
    frame_e                           frame;
    frame_e                           next_frame;
    logic [3:0]                       bit_cnt;  // rising scl edges seen in this frame
    logic [7:0]                       shift;
    logic [2:0]                       block;
    logic [eeprom_pkg::ADDR_BITS-1:0] addr;
    logic                             scl_prev;
    logic                             sda_prev;

    initial begin
        for (int i = 0; i < eeprom_pkg::MEM_BYTES; i++) begin
            mem[i] = 8'hff;  // erased part
        end
        frame      = F_IGNORE;
        next_frame = F_IGNORE;
        bit_cnt    = 4'd0;
        shift      = 8'h00;
        block      = 3'd0;
        addr       = '0;
        sda_low    = 1'b0;
        scl_prev   = 1'b1;
        sda_prev   = 1'b1;
    end

    always @(scl or sda) begin
        if (scl === 1'b1 && scl_prev === 1'b1 && sda_prev === 1'b1 && sda === 1'b0) begin
            frame   = F_CTRL;  // start or repeated start
            bit_cnt = 4'd0;
            sda_low = 1'b0;
        end else if (scl === 1'b1 && scl_prev === 1'b1 && sda_prev === 1'b0 && sda === 1'b1) begin
            frame   = F_IGNORE;  // stop
            sda_low = 1'b0;
        end else if (scl_prev === 1'b0 && scl === 1'b1) begin
            if (bit_cnt < 4'd8 && frame != F_DATA_R) begin
                shift = {shift[6:0], sda};
            end
            bit_cnt = bit_cnt + 4'd1;
        end else if (scl_prev === 1'b1 && scl === 1'b0) begin
            if (bit_cnt == 4'd8) begin
                // ack slot, the byte is complete
                sda_low    = 1'b1;
                next_frame = F_IGNORE;
                case (frame)
                    F_CTRL: begin
                        if (shift[7:4] == device_code) begin
                            block      = shift[3:1];
                            next_frame = shift[0] ? F_DATA_R : F_WORD;
                        end else begin
                            sda_low = 1'b0;  // not addressed
                        end
                    end
                    F_WORD: begin
                        addr       = {block, shift};
                        next_frame = F_DATA_W;
                    end
                    F_DATA_W: mem[addr] = shift;
                    default:  sda_low = 1'b0;  // master answers a read byte
                endcase
            end else if (bit_cnt == 4'd9) begin
                bit_cnt = 4'd0;
                frame   = next_frame;
                sda_low = (frame == F_DATA_R) && !mem[addr][7];
            end else if (frame == F_DATA_R && bit_cnt != 4'd0) begin
                sda_low = !mem[addr][3'(7 - bit_cnt)];
            end
        end
        scl_prev = scl;
        sda_prev = sda;
    end

endmodule

//--- hdl/eeprom_rw_top.sv
module eeprom_rw_top (
    input  logic                    CLK,
    input  logic                    RESET,
    input  logic                    req_valid,
    input  eeprom_pkg::eeprom_req_t req,
    output logic                    busy,
    output logic                    rsp_valid,
    output eeprom_pkg::eeprom_rsp_t rsp,
    output logic                    scl,
    output logic                    sda_low,
    input  logic                    sda_in
);

    logic                   q0;
    logic                   q1;
    logic                   q2;
    logic                   q3;
    logic                   timer_en;
    logic                   cond_go;
    eeprom_pkg::cond_kind_e cond_kind;
    logic                   cond_done;
    logic                   cond_scl;
    logic                   cond_sda_low;
    logic                   byte_go;
    eeprom_pkg::byte_cmd_t  byte_cmd;
    logic                   byte_done;
    logic [7:0]             rx_byte;
    logic                   ack_seen;
    logic                   byte_scl;
    logic                   byte_sda_low;

    i2c_bit_timer u_timer (
        .CLK    (CLK),
        .RESET  (RESET),
        .enable (timer_en),
        .q0     (q0),
        .q1     (q1),
        .q2     (q2),
        .q3     (q3)
    );

    i2c_bus_cond u_cond (
        .CLK     (CLK),
        .RESET   (RESET),
        .go      (cond_go),
        .kind    (cond_kind),
        .q0      (q0),
        .q1      (q1),
        .q2      (q2),
        .q3      (q3),
        .scl     (cond_scl),
        .sda_low (cond_sda_low),
        .done    (cond_done)
    );

    i2c_byte_shifter u_shifter (
        .CLK      (CLK),
        .RESET    (RESET),
        .go       (byte_go),
        .cmd      (byte_cmd),
        .q0       (q0),
        .q1       (q1),
        .q2       (q2),
        .q3       (q3),
        .sda_in   (sda_in),
        .scl      (byte_scl),
        .sda_low  (byte_sda_low),
        .rx_byte  (rx_byte),
        .ack_seen (ack_seen),
        .done     (byte_done)
    );

    eeprom_ctrl u_ctrl (
        .CLK       (CLK),
        .RESET     (RESET),
        .req_valid (req_valid),
        .req       (req),
        .busy      (busy),
        .rsp_valid (rsp_valid),
        .rsp       (rsp),
        .timer_en  (timer_en),
        .cond_go   (cond_go),
        .cond_kind (cond_kind),
        .cond_done (cond_done),
        .byte_go   (byte_go),
        .byte_cmd  (byte_cmd),
        .byte_done (byte_done),
        .rx_byte   (rx_byte),
        .ack_seen  (ack_seen)
    );

    // an idle unit parks scl high, so the AND follows whichever one runs
    assign scl     = cond_scl & byte_scl;
    assign sda_low = cond_sda_low | byte_sda_low;  // open-drain pull-downs

endmodule

//--- hdl/eeprom_ctrl.sv
module eeprom_ctrl (
    input  logic                    CLK,
    input  logic                    RESET,
    input  logic                    req_valid,
    input  eeprom_pkg::eeprom_req_t req,
    output logic                    busy,
    output logic                    rsp_valid,
    output eeprom_pkg::eeprom_rsp_t rsp,
    output logic                    timer_en,
    output logic                    cond_go,
    output eeprom_pkg::cond_kind_e  cond_kind,
    input  logic                    cond_done,
    output logic                    byte_go,
    output eeprom_pkg::byte_cmd_t   byte_cmd,
    input  logic                    byte_done,
    input  logic [7:0]              rx_byte,
    input  logic                    ack_seen
);

    typedef enum logic [3:0] {
        S_IDLE,
        S_LAUNCH,
        S_START,
        S_CTRL_W,
        S_WORD,
        S_DATA_W,
        S_RESTART,
        S_CTRL_R,
        S_DATA_R,
        S_STOP,
        S_RESP
    } state_e;

    state_e                  state_q;
    state_e                  state_d;
    eeprom_pkg::eeprom_req_t req_q;
    logic                    ack_err_q;
    logic [7:0]              rdata_q;
    logic                    go_stop;
    logic                    sent_byte;
    logic [7:0]              ctrl_wr;
    logic [7:0]              ctrl_rd;

    function automatic eeprom_pkg::byte_cmd_t send_cmd(input logic [7:0] b);
        eeprom_pkg::byte_cmd_t c;
        c.receive    = 1'b0;
        c.tx_byte    = b;
        c.master_ack = 1'b1;
        return c;
    endfunction

    assign ctrl_wr = {eeprom_pkg::DEVICE_CODE, req_q.addr.split.block, 1'b0};
    assign ctrl_rd = {eeprom_pkg::DEVICE_CODE, req_q.addr.split.block, 1'b1};

    assign busy      = (state_q != S_IDLE);
    assign rsp_valid = (state_q == S_RESP);

    // bytes whose ninth bit comes from the slave
    assign sent_byte = byte_done && (state_q == S_CTRL_W || state_q == S_WORD ||
                                     state_q == S_DATA_W || state_q == S_CTRL_R);

    // the next unit is launched in the done cycle, so the bus never idles
    always_comb begin
        state_d   = state_q;
        cond_go   = 1'b0;
        cond_kind = eeprom_pkg::COND_START;
        byte_go   = 1'b0;
        byte_cmd  = send_cmd(8'h00);
        go_stop   = 1'b0;
        case (state_q)
            S_IDLE: begin
                if (req_valid) begin
                    state_d = S_LAUNCH;
                end
            end
            S_LAUNCH: begin
                cond_go = 1'b1;  // timer just enabled, q0 is here
                state_d = S_START;
            end
            S_START: begin
                if (cond_done) begin
                    byte_go  = 1'b1;
                    byte_cmd = send_cmd(ctrl_wr);
                    state_d  = S_CTRL_W;
                end
            end
            S_CTRL_W: begin
                if (byte_done) begin
                    if (ack_seen) begin
                        go_stop = 1'b1;
                    end else begin
                        byte_go  = 1'b1;
                        byte_cmd = send_cmd(req_q.addr.split.word);
                        state_d  = S_WORD;
                    end
                end
            end
            S_WORD: begin
                if (byte_done) begin
                    if (ack_seen) begin
                        go_stop = 1'b1;
                    end else if (req_q.write) begin
                        byte_go  = 1'b1;
                        byte_cmd = send_cmd(req_q.wdata);
                        state_d  = S_DATA_W;
                    end else begin
                        cond_go   = 1'b1;
                        cond_kind = eeprom_pkg::COND_RESTART;
                        state_d   = S_RESTART;
                    end
                end
            end
            S_DATA_W: begin
                go_stop = byte_done;
            end
            S_RESTART: begin
                if (cond_done) begin
                    byte_go  = 1'b1;
                    byte_cmd = send_cmd(ctrl_rd);
                    state_d  = S_CTRL_R;
                end
            end
            S_CTRL_R: begin
                if (byte_done) begin
                    if (ack_seen) begin
                        go_stop = 1'b1;
                    end else begin
                        byte_go             = 1'b1;
                        byte_cmd.receive    = 1'b1;
                        byte_cmd.master_ack = 1'b1;  // nack ends the single read
                        state_d             = S_DATA_R;
                    end
                end
            end
            S_DATA_R: begin
                go_stop = byte_done;
            end
            S_STOP: begin
                if (cond_done) begin
                    state_d = S_RESP;
                end
            end
            S_RESP: begin
                state_d = S_IDLE;
            end
            default: begin
                state_d = S_IDLE;
            end
        endcase
        if (go_stop) begin
            cond_go   = 1'b1;
            cond_kind = eeprom_pkg::COND_STOP;
            state_d   = S_STOP;
        end
    end

    always_ff @(posedge CLK) begin
        if (RESET) begin
            state_q   <= S_IDLE;
            timer_en  <= 1'b0;
            ack_err_q <= 1'b0;
        end else begin
            state_q <= state_d;
            if (state_q == S_IDLE && req_valid) begin
                timer_en  <= 1'b1;
                ack_err_q <= 1'b0;
            end else if (state_q == S_STOP && cond_done) begin
                timer_en <= 1'b0;
            end
            if (sent_byte && ack_seen) begin
                ack_err_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (state_q == S_IDLE && req_valid) begin
            req_q <= req;
        end
        if (state_q == S_DATA_R && byte_done) begin
            rdata_q <= rx_byte;
        end
        if (state_q == S_STOP && cond_done) begin
            rsp.rdata     <= rdata_q;  // stays until the next completion
            rsp.ack_error <= ack_err_q;
        end
    end

endmodule

//--- hdl/i2c_byte_shifter.sv
module i2c_byte_shifter (
    input  logic                  CLK,
    input  logic                  RESET,
    input  logic                  go,
    input  eeprom_pkg::byte_cmd_t cmd,
    input  logic                  q0,
    input  logic                  q1,
    input  logic                  q2,
    input  logic                  q3,
    input  logic                  sda_in,
    output logic                  scl,
    output logic                  sda_low,
    output logic [7:0]            rx_byte,
    output logic                  ack_seen,
    output logic                  done
);

    logic       active;
    logic [3:0] bit_cnt;   // 0..7 data, 8 = ack bit
    logic [7:0] shift_q;
    logic       receive_q;
    logic       master_ack_q;
    logic       ack_bit;

    assign ack_bit = (bit_cnt == 4'd8);
    assign done    = active && q0 && ack_bit;
    assign rx_byte = shift_q;

    always_ff @(posedge CLK) begin
        if (RESET) begin
            active  <= 1'b0;
            bit_cnt <= 4'd0;
            scl     <= 1'b1;
            sda_low <= 1'b0;
        end else if (go) begin
            // go lands on a q0, so this is already the low phase of bit 7
            active  <= 1'b1;
            bit_cnt <= 4'd0;
            scl     <= 1'b0;
        end else if (active) begin
            if (q0) begin
                if (ack_bit) begin
                    active <= 1'b0;
                    scl    <= 1'b1;  // released for the next unit
                end else begin
                    bit_cnt <= bit_cnt + 4'd1;
                    scl     <= 1'b0;
                end
            end
            if (q1) begin
                if (!ack_bit) begin
                    sda_low <= !receive_q && !shift_q[7];
                end else begin
                    sda_low <= receive_q && !master_ack_q;  // slave acks a sent byte
                end
            end
            if (q2) begin
                scl <= 1'b1;
            end
        end else if (q1) begin
            sda_low <= 1'b0;
        end
    end

    // sent bits shift back in too, so one register serves both directions
    always_ff @(posedge CLK) begin
        if (go) begin
            shift_q      <= cmd.tx_byte;
            receive_q    <= cmd.receive;
            master_ack_q <= cmd.master_ack;
        end else if (active && q3) begin
            if (!ack_bit) begin
                shift_q <= {shift_q[6:0], sda_in};
            end else begin
                ack_seen <= sda_in;  // 1 = not acknowledged
            end
        end
    end

endmodule

//--- hdl/i2c_bus_cond.sv
module i2c_bus_cond (
    input  logic                   CLK,
    input  logic                   RESET,
    input  logic                   go,
    input  eeprom_pkg::cond_kind_e kind,
    input  logic                   q0,
    input  logic                   q1,
    input  logic                   q2,
    input  logic                   q3,
    output logic                   scl,
    output logic                   sda_low,
    output logic                   done
);

    logic                   active;
    eeprom_pkg::cond_kind_e kind_q;

    // period runs from the q0 of go to the next q0
    assign done = active && q0;

    always_ff @(posedge CLK) begin
        if (RESET) begin
            active  <= 1'b0;
            kind_q  <= eeprom_pkg::COND_START;
            scl     <= 1'b1;
            sda_low <= 1'b0;
        end else if (go) begin
            active <= 1'b1;
            kind_q <= kind;
            scl    <= (kind == eeprom_pkg::COND_START);  // a first start keeps scl high
        end else if (active) begin
            if (q0) begin
                active <= 1'b0;
                scl    <= 1'b1;  // hand scl to the next unit
            end
            if (q1) begin
                // stop needs sda low before scl rises, restart needs it high
                sda_low <= (kind_q == eeprom_pkg::COND_STOP);
            end
            if (q2) begin
                scl <= 1'b1;
            end
            if (q3) begin
                sda_low <= (kind_q != eeprom_pkg::COND_STOP);  // the edge with scl high
            end
        end else if (q1) begin
            sda_low <= 1'b0;  // a held start level ends under scl low
        end
    end

endmodule

//--- hdl/i2c_bit_timer.sv
module i2c_bit_timer (
    input  logic CLK,
    input  logic RESET,
    input  logic enable,
    output logic q0,
    output logic q1,
    output logic q2,
    output logic q3
);

    logic [eeprom_pkg::QUARTER_CNT_BITS-1:0] quarter_cnt;
    logic [1:0]                              phase;
    logic                                    quarter_end;
    logic                                    tick;

    assign quarter_end = (quarter_cnt ==
                          eeprom_pkg::QUARTER_CNT_BITS'(eeprom_pkg::QUARTER_CYCLES - 1));

    // counters sit at zero while disabled, so the first enabled cycle is a q0
    always_ff @(posedge CLK) begin
        if (RESET || !enable) begin
            quarter_cnt <= '0;
            phase       <= 2'd0;
        end else if (quarter_end) begin
            quarter_cnt <= '0;
            phase       <= phase + 2'd1;  // wraps after q3
        end else begin
            quarter_cnt <= quarter_cnt + 1'b1;
        end
    end

    // one strobe at the first cycle of each quarter
    assign tick = enable && (quarter_cnt == '0);

    assign q0 = tick && (phase == 2'd0);  // scl falls
    assign q1 = tick && (phase == 2'd1);  // sda may change
    assign q2 = tick && (phase == 2'd2);  // scl rises
    assign q3 = tick && (phase == 2'd3);  // sample point

endmodule

//--- hdl/eeprom_pkg.sv
package eeprom_pkg;

    // bus timing
    localparam int QUARTER_CYCLES   = 4;  // CLK cycles per quarter of an SCL period
    localparam int QUARTER_CNT_BITS = (QUARTER_CYCLES > 1) ? $clog2(QUARTER_CYCLES) : 1;

    // 24C16 addressing
    localparam logic [3:0] DEVICE_CODE = 4'b1010;
    localparam int         ADDR_BITS   = 11;
    localparam int         MEM_BYTES   = 2048;

    typedef struct packed {
        logic [2:0] block;  // goes into the control byte
        logic [7:0] word;   // word-address byte
    } eeprom_split_t;

    // the host sees a flat address, the bus wants it split
    typedef union packed {
        logic [ADDR_BITS-1:0] flat;
        eeprom_split_t        split;
    } eeprom_addr_u;

    typedef struct packed {
        logic         write;  // 0 = read
        eeprom_addr_u addr;
        logic [7:0]   wdata;
    } eeprom_req_t;

    typedef struct packed {
        logic [7:0] rdata;
        logic       ack_error;
    } eeprom_rsp_t;

    typedef enum logic [1:0] {
        COND_START,
        COND_RESTART,
        COND_STOP
    } cond_kind_e;

    typedef struct packed {
        logic       receive;
        logic [7:0] tx_byte;
        logic       master_ack;  // ninth-bit level when receiving, 1 = nack
    } byte_cmd_t;

endpackage
